// File: verilog/pool_config.svh
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

// Width of one sample coming out of the systolic array
`define POOL_DATA_WIDTH 16

// Number of pooling columns, one per array column
`define POOL_COLUMNS 8

// Samples per feature map row, must be even
`define POOL_ROW_LEN 8

// Rows per feature map, must be even
`define POOL_ROWS 4

// Row buffer address width, 2**width must cover half a row
`define POOL_ADDR_WIDTH 2

`endif

// File: verilog/pool_data_pkg.sv
`default_nettype none

`include "pool_config.svh"

package pool_data_pkg;

    // One unsigned sample as delivered by the systolic array
    typedef logic [`POOL_DATA_WIDTH-1:0] sample_t;

    // Two extra bits so that the sum of a 2x2 window never wraps
    typedef logic [`POOL_DATA_WIDTH+1:0] acc_t;

    // Row buffer entry index, one entry per window in a row
    typedef logic [`POOL_ADDR_WIDTH-1:0] buf_addr_t;

endpackage

`default_nettype wire

// File: verilog/pool_ctrl_pkg.sv
`default_nettype none

package pool_ctrl_pkg;

    typedef enum logic
    {
        POOL_MAX = 1'b0,  // Largest value of the window
        POOL_AVG = 1'b1   // Window sum divided by four
    } pool_mode_t;

    typedef enum logic [1:0]
    {
        IDLE     = 2'd0,
        ROW_EVEN = 2'd1,  // First row of a row pair
        ROW_ODD  = 2'd2   // Second row, windows complete here
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/pool_row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_row_buffer
    import pool_data_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      wr_in,
    input  logic      wr_res,
    input  buf_addr_t addr,
    input  sample_t   sample_in,
    input  acc_t      result_in,
    output acc_t      rd_data
);

    localparam int DEPTH = 2 ** `POOL_ADDR_WIDTH;

    acc_t entries [DEPTH];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (wr_in)
        begin
            entries[addr] <= acc_t'(sample_in);  // First sample of a window opens the entry
        end
        else if (wr_res)
        begin
            entries[addr] <= result_in;  // Partial result of the even row
        end
    end

    assign rd_data = entries[addr];  // Read is combinational so the ALU sees it in the same cycle

endmodule

`default_nettype wire

// File: verilog/pool_alu.sv
`timescale 1ns/1ps
`default_nettype none

module pool_alu
    import pool_data_pkg::*, pool_ctrl_pkg::*;
(
    input  sample_t    a,
    input  acc_t       b,
    input  pool_mode_t mode,
    input  logic       last,
    output acc_t       result,
    output sample_t    final_out
);

    acc_t a_ext;

    assign a_ext = acc_t'(a);  // Samples are unsigned so zero extension is enough

    always_comb
    begin
        if (mode == POOL_AVG)
            result = a_ext + b;  // Cannot overflow with two guard bits
        else
            result = (a_ext > b) ? a_ext : b;
    end

    // The finished value only exists on the last step of a window
    always_comb
    begin
        if (!last)
            final_out = '0;
        else if (mode == POOL_AVG)
            final_out = sample_t'(result >> 2);  // Divide the four-sample sum by four
        else
            final_out = sample_t'(result);  // A maximum always fits in one sample
    end

endmodule

`default_nettype wire

// File: verilog/pool_column.sv
`timescale 1ns/1ps
`default_nettype none

module pool_column
    import pool_data_pkg::*, pool_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  sample_t    sample,
    input  buf_addr_t  buf_addr,
    input  logic       buf_wr_in,
    input  logic       buf_wr_res,
    input  logic       fb_sel,
    input  logic       fb_load,
    input  logic       last,
    input  pool_mode_t mode,
    output sample_t    pool_out,
    output logic       pool_done
);

    acc_t    buf_rd;
    acc_t    fb_q;
    acc_t    operand_b;
    acc_t    alu_result;
    sample_t alu_final;

    pool_row_buffer u_row_buffer (
        .clk       (clk),
        .nrst      (nrst),
        .wr_in     (buf_wr_in),
        .wr_res    (buf_wr_res),
        .addr      (buf_addr),
        .sample_in (sample),
        .result_in (alu_result),
        .rd_data   (buf_rd)
    );

    assign operand_b = fb_sel ? fb_q : buf_rd;  // Final step of a window uses the feedback value

    pool_alu u_alu (
        .a         (sample),
        .b         (operand_b),
        .mode      (mode),
        .last      (last),
        .result    (alu_result),
        .final_out (alu_final)
    );

    always_ff @(posedge clk)
    begin
        if (fb_load)
            fb_q <= alu_result;  // Three of four samples combined
        if (last)
            pool_out <= alu_final;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            pool_done <= 1'b0;
        else
            pool_done <= last;  // One cycle after the window's final sample
    end

endmodule

`default_nettype wire

// File: verilog/pool_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_control
    import pool_data_pkg::*, pool_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  pool_mode_t mode,
    output logic       busy,
    output buf_addr_t  buf_addr,
    output logic       buf_wr_in,
    output logic       buf_wr_res,
    output logic       fb_sel,
    output logic       fb_load,
    output logic       last,
    output pool_mode_t mode_out,
    output logic       finish_req
);

    localparam int COL_W  = $clog2(`POOL_ROW_LEN);
    localparam int PAIRS  = `POOL_ROWS / 2;
    localparam int PAIR_W = (PAIRS > 1) ? $clog2(PAIRS) : 1;

    ctrl_state_t       state;
    logic [COL_W-1:0]  col_cnt;
    logic [PAIR_W-1:0] pair_cnt;
    pool_mode_t        mode_q;
    logic              active;
    logic              row_odd;
    logic              col_odd;
    logic              row_end;
    logic              frame_end;

    assign active    = (state != IDLE);
    assign row_odd   = (state == ROW_ODD);
    assign col_odd   = col_cnt[0];
    assign row_end   = (col_cnt == COL_W'(`POOL_ROW_LEN - 1));
    assign frame_end = row_end && (pair_cnt == PAIR_W'(PAIRS - 1));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state    <= IDLE;
            col_cnt  <= '0;
            pair_cnt <= '0;
            mode_q   <= POOL_MAX;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state    <= ROW_EVEN;
                        col_cnt  <= '0;
                        pair_cnt <= '0;
                        mode_q   <= mode;  // Held for the whole frame
                    end
                end
                ROW_EVEN:
                begin
                    col_cnt <= row_end ? '0 : col_cnt + 1'b1;
                    if (row_end)
                        state <= ROW_ODD;
                end
                ROW_ODD:
                begin
                    col_cnt <= row_end ? '0 : col_cnt + 1'b1;
                    if (frame_end)
                    begin
                        state <= IDLE;  // Start in the next cycle is accepted
                    end
                    else if (row_end)
                    begin
                        state    <= ROW_EVEN;
                        pair_cnt <= pair_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Window step decode from row parity and column parity
    assign buf_wr_in  = active && !row_odd && !col_odd;
    assign buf_wr_res = active && !row_odd && col_odd;
    assign fb_load    = active && row_odd && !col_odd;
    assign fb_sel     = active && row_odd && col_odd;
    assign last       = fb_sel;
    assign finish_req = fb_sel && frame_end;

    assign buf_addr = buf_addr_t'(col_cnt >> 1);  // One entry per window in the row
    assign mode_out = mode_q;
    assign busy     = active;

endmodule

`default_nettype wire

// File: verilog/pool_skew_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pool_skew_stage
    import pool_data_pkg::*, pool_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  buf_addr_t  in_buf_addr,
    input  logic       in_buf_wr_in,
    input  logic       in_buf_wr_res,
    input  logic       in_fb_sel,
    input  logic       in_fb_load,
    input  logic       in_last,
    input  pool_mode_t in_mode,
    input  logic       in_finish_req,
    output buf_addr_t  out_buf_addr,
    output logic       out_buf_wr_in,
    output logic       out_buf_wr_res,
    output logic       out_fb_sel,
    output logic       out_fb_load,
    output logic       out_last,
    output pool_mode_t out_mode,
    output logic       out_finish_req
);

    // Strobes and the finish request follow the previous column by one cycle
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            out_buf_wr_in  <= 1'b0;
            out_buf_wr_res <= 1'b0;
            out_fb_sel     <= 1'b0;
            out_fb_load    <= 1'b0;
            out_last       <= 1'b0;
            out_finish_req <= 1'b0;
        end
        else
        begin
            out_buf_wr_in  <= in_buf_wr_in;
            out_buf_wr_res <= in_buf_wr_res;
            out_fb_sel     <= in_fb_sel;
            out_fb_load    <= in_fb_load;
            out_last       <= in_last;
            out_finish_req <= in_finish_req;
        end
    end

    always_ff @(posedge clk)
    begin
        out_buf_addr <= in_buf_addr;  // Address and mode move with their strobes
        out_mode     <= in_mode;
    end

endmodule

`default_nettype wire

// File: verilog/pool_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_top
    import pool_data_pkg::*, pool_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  pool_mode_t mode,
    input  sample_t    sys_out   [`POOL_COLUMNS],
    output sample_t    pool_out  [`POOL_COLUMNS],
    output logic       pool_done [`POOL_COLUMNS],
    output logic       busy,
    output logic       finish
);

    // Control bundle as seen by each column
    buf_addr_t  c_addr    [`POOL_COLUMNS];
    logic       c_wr_in   [`POOL_COLUMNS];
    logic       c_wr_res  [`POOL_COLUMNS];
    logic       c_fb_sel  [`POOL_COLUMNS];
    logic       c_fb_load [`POOL_COLUMNS];
    logic       c_last    [`POOL_COLUMNS];
    pool_mode_t c_mode    [`POOL_COLUMNS];
    logic       c_finish  [`POOL_COLUMNS];

    pool_control u_control (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .mode       (mode),
        .busy       (busy),
        .buf_addr   (c_addr[0]),
        .buf_wr_in  (c_wr_in[0]),
        .buf_wr_res (c_wr_res[0]),
        .fb_sel     (c_fb_sel[0]),
        .fb_load    (c_fb_load[0]),
        .last       (c_last[0]),
        .mode_out   (c_mode[0]),
        .finish_req (c_finish[0])
    );

    genvar j;
    generate
        for (j = 1; j < `POOL_COLUMNS; j++)
        begin : g_skew
            pool_skew_stage u_stage (
                .clk (clk), .nrst (nrst),
                .in_buf_addr    (c_addr[j-1]),    .out_buf_addr   (c_addr[j]),
                .in_buf_wr_in   (c_wr_in[j-1]),   .out_buf_wr_in  (c_wr_in[j]),
                .in_buf_wr_res  (c_wr_res[j-1]),  .out_buf_wr_res (c_wr_res[j]),
                .in_fb_sel      (c_fb_sel[j-1]),  .out_fb_sel     (c_fb_sel[j]),
                .in_fb_load     (c_fb_load[j-1]), .out_fb_load    (c_fb_load[j]),
                .in_last        (c_last[j-1]),    .out_last       (c_last[j]),
                .in_mode        (c_mode[j-1]),    .out_mode       (c_mode[j]),
                .in_finish_req  (c_finish[j-1]),  .out_finish_req (c_finish[j])
            );
        end

        for (j = 0; j < `POOL_COLUMNS; j++)
        begin : g_column
            pool_column u_column (
                .clk        (clk),
                .nrst       (nrst),
                .sample     (sys_out[j]),
                .buf_addr   (c_addr[j]),
                .buf_wr_in  (c_wr_in[j]),
                .buf_wr_res (c_wr_res[j]),
                .fb_sel     (c_fb_sel[j]),
                .fb_load    (c_fb_load[j]),
                .last       (c_last[j]),
                .mode       (c_mode[j]),
                .pool_out   (pool_out[j]),
                .pool_done  (pool_done[j])
            );
        end
    endgenerate

    // Extra stage so finish lines up with the last column's done strobe
    pool_skew_stage u_finish_stage (
        .clk (clk), .nrst (nrst),
        .in_buf_addr    ('0),                           .out_buf_addr   (),
        .in_buf_wr_in   (1'b0),                         .out_buf_wr_in  (),
        .in_buf_wr_res  (1'b0),                         .out_buf_wr_res (),
        .in_fb_sel      (1'b0),                         .out_fb_sel     (),
        .in_fb_load     (1'b0),                         .out_fb_load    (),
        .in_last        (1'b0),                         .out_last       (),
        .in_mode        (POOL_MAX),                     .out_mode       (),
        .in_finish_req  (c_finish[`POOL_COLUMNS-1]),    .out_finish_req (finish)
    );

endmodule

`default_nettype wire

// File: verification/pool_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pool_clock_gen
(
    output logic clk,
    output logic nrst
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial
    begin
        nrst = 1'b0;
        repeat (3) @(negedge clk);
        nrst = 1'b1;  // Released half a cycle away from the rising edge
    end

endmodule

`default_nettype wire

// File: verification/pool_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_checker
    import pool_data_pkg::*, pool_ctrl_pkg::*;
#(
    parameter int MAX_FRAMES = 8
)
(
    input  logic       clk,
    input  int         cycle,
    input  sample_t    pool_out    [`POOL_COLUMNS],
    input  logic       pool_done   [`POOL_COLUMNS],
    input  logic       finish,
    input  sample_t    frame_data  [MAX_FRAMES * `POOL_COLUMNS * `POOL_ROWS * `POOL_ROW_LEN],
    input  pool_mode_t frame_mode  [MAX_FRAMES],
    input  int         frame_start [MAX_FRAMES],
    input  int         frame_cnt,
    output int         errors,
    output int         checks,
    output int         finish_seen
);

    localparam int COLUMNS      = `POOL_COLUMNS;
    localparam int ROW_LEN      = `POOL_ROW_LEN;
    localparam int FRAME_LEN    = `POOL_ROWS * `POOL_ROW_LEN;
    localparam int WINDOWS      = (`POOL_ROWS / 2) * (`POOL_ROW_LEN / 2);
    localparam int FINISH_DELAY = FRAME_LEN + COLUMNS;  // Start to the last column's final result

    int      win_idx [COLUMNS] = '{default: 0};  // Results seen so far on each column
    int      err_cnt = 0;
    int      chk_cnt = 0;
    int      fin_cnt = 0;
    int      frame_idx;
    int      win_num;
    sample_t expected;

    // Reference result of window w of frame f on column j
    function automatic sample_t window_result(input int f, input int j, input int w);
        int   p;
        int   q;
        int   base;
        acc_t s [4];
        acc_t best;
        acc_t sum;
        p    = w / (ROW_LEN / 2);
        q    = w % (ROW_LEN / 2);
        base = (f * COLUMNS + j) * FRAME_LEN + 2 * p * ROW_LEN + 2 * q;
        s[0] = acc_t'(frame_data[base]);
        s[1] = acc_t'(frame_data[base + 1]);
        s[2] = acc_t'(frame_data[base + ROW_LEN]);
        s[3] = acc_t'(frame_data[base + ROW_LEN + 1]);
        best = s[0];
        sum  = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (s[i] > best)
                best = s[i];
            sum = sum + s[i];
        end
        if (frame_mode[f] == POOL_AVG)
            return sample_t'(sum >> 2);
        else
            return sample_t'(best);
    endfunction

    // Outputs are registered on the rising edge, so they are read on the falling one
    always @(negedge clk)
    begin
        for (int j = 0; j < COLUMNS; j++)
        begin
            if (pool_done[j])
            begin
                frame_idx  = win_idx[j] / WINDOWS;
                win_num    = win_idx[j] % WINDOWS;
                win_idx[j] = win_idx[j] + 1;
                if (frame_idx >= frame_cnt)
                begin
                    $display("extra pool_done on column %0d at %0t, no window was due", j, $time);
                    err_cnt++;
                end
                else
                begin
                    expected = window_result(frame_idx, j, win_num);
                    chk_cnt++;
                    if (pool_out[j] !== expected)
                    begin
                        $display("CHECK FAILED t=%0t pool_out[%0d] expected %h got %h",
                                 $time, j, expected, pool_out[j]);
                        err_cnt++;
                    end
                end
            end
        end

        if (finish)
        begin
            if (fin_cnt >= frame_cnt)
            begin
                $display("finish pulsed at %0t while no frame was outstanding", $time);
                err_cnt++;
            end
            else
            begin
                chk_cnt++;
                if (cycle != frame_start[fin_cnt] + FINISH_DELAY)
                begin
                    $display("finish for frame %0d came in cycle %0d instead of cycle %0d",
                             fin_cnt, cycle, frame_start[fin_cnt] + FINISH_DELAY);
                    err_cnt++;
                end
                // Every column has delivered the whole frame by now
                for (int j = 0; j < COLUMNS; j++)
                begin
                    if (win_idx[j] != (fin_cnt + 1) * WINDOWS)
                    begin
                        $display("column %0d gave %0d results by finish of frame %0d, not %0d",
                                 j, win_idx[j], fin_cnt, (fin_cnt + 1) * WINDOWS);
                        err_cnt++;
                    end
                end
            end
            fin_cnt++;
        end

        errors      <= err_cnt;
        checks      <= chk_cnt;
        finish_seen <= fin_cnt;
    end

endmodule

`default_nettype wire

// File: verification/pool_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_tb
    import pool_data_pkg::*, pool_ctrl_pkg::*;
();

    localparam int          COLUMNS    = `POOL_COLUMNS;
    localparam int          FRAME_LEN  = `POOL_ROWS * `POOL_ROW_LEN;
    localparam int          MAX_FRAMES = 8;
    localparam int          TIMEOUT    = 6 * (FRAME_LEN + COLUMNS + 4) + 50;
    localparam logic [31:0] SEED       = 32'hb104_3ec1;

    typedef enum int { FILL_RANDOM, FILL_ONES, FILL_ZEROS } fill_t;

    logic       clk;
    logic       nrst;
    logic       start;
    pool_mode_t mode;
    sample_t    sys_out   [COLUMNS] = '{default: '0};
    sample_t    pool_out  [COLUMNS];
    logic       pool_done [COLUMNS];
    logic       busy;
    logic       finish;

    int          cycle = 0;  // Rising edges since time zero
    logic [31:0] rng;
    sample_t     frame_data  [MAX_FRAMES * COLUMNS * FRAME_LEN];
    pool_mode_t  frame_mode  [MAX_FRAMES];
    int          frame_start [MAX_FRAMES];
    int          frame_cnt = 0;
    int          tb_errors = 0;
    int          test_cnt  = 0;
    int          chk_errors;
    int          chk_count;
    int          finish_seen;
    int          drive_idx;

    pool_clock_gen clock_gen (
        .clk  (clk),
        .nrst (nrst)
    );

    pool_top uut (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .mode      (mode),
        .sys_out   (sys_out),
        .pool_out  (pool_out),
        .pool_done (pool_done),
        .busy      (busy),
        .finish    (finish)
    );

    pool_checker #(.MAX_FRAMES(MAX_FRAMES)) u_checker (
        .clk         (clk),
        .cycle       (cycle),
        .pool_out    (pool_out),
        .pool_done   (pool_done),
        .finish      (finish),
        .frame_data  (frame_data),
        .frame_mode  (frame_mode),
        .frame_start (frame_start),
        .frame_cnt   (frame_cnt),
        .errors      (chk_errors),
        .checks      (chk_count),
        .finish_seen (finish_seen)
    );

    always @(posedge clk)
        cycle <= cycle + 1;

    // Column j gets sample c-1-j of every frame in flight, zero elsewhere
    always @(negedge clk)
    begin
        for (int j = 0; j < COLUMNS; j++)
        begin
            sys_out[j] = '0;
            for (int f = 0; f < frame_cnt; f++)
            begin
                drive_idx = cycle - frame_start[f] - 1 - j;
                if (drive_idx >= 0 && drive_idx < FRAME_LEN)
                    sys_out[j] = frame_data[(f * COLUMNS + j) * FRAME_LEN + drive_idx];
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors;
    endfunction

    task automatic fill_frame(input int f, input fill_t kind);
        for (int i = 0; i < COLUMNS * FRAME_LEN; i++)
        begin
            if (kind == FILL_RANDOM)
            begin
                rng = xorshift32(rng);
                frame_data[f * COLUMNS * FRAME_LEN + i] = sample_t'(rng >> (32 - `POOL_DATA_WIDTH));
            end
            else if (kind == FILL_ONES)
                frame_data[f * COLUMNS * FRAME_LEN + i] = '1;
            else
                frame_data[f * COLUMNS * FRAME_LEN + i] = '0;
        end
    endtask

    // Called on a falling edge, returns one falling edge after the start strobe
    task automatic launch_frame(input pool_mode_t m, input fill_t kind);
        fill_frame(frame_cnt, kind);
        while (busy)
            @(negedge clk);
        start                  = 1'b1;
        mode                   = m;
        frame_mode[frame_cnt]  = m;
        frame_start[frame_cnt] = cycle;
        frame_cnt++;
        @(negedge clk);
        start = 1'b0;
    endtask

    // A follow-on frame must start in the first cycle with busy low
    task automatic check_restart_gap(input int f);
        if (frame_start[f] - frame_start[f - 1] != FRAME_LEN + 1)
        begin
            $display("frame %0d started %0d cycles after frame %0d, expected %0d",
                     f, frame_start[f] - frame_start[f - 1], f - 1, FRAME_LEN + 1);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        int new_errors;
        while (finish_seen < frame_cnt)
            @(negedge clk);
        repeat (2) @(negedge clk);  // Room for stray strobes
        new_errors = total_errors() - err_before;
        test_cnt++;
        if (new_errors == 0)
            $display("test %0d, %s: ok", test_cnt, name);
        else
            $display("test %0d, %s: %0d errors", test_cnt, name, new_errors);
    endtask

    initial
    begin
        int err_before;

        start = 1'b0;
        mode  = POOL_MAX;
        rng   = SEED;
        @(posedge nrst);
        @(negedge clk);

        err_before = total_errors();
        launch_frame(POOL_MAX, FILL_RANDOM);
        end_test("max pool of random samples", err_before);

        err_before = total_errors();
        launch_frame(POOL_AVG, FILL_RANDOM);
        end_test("average pool of random samples", err_before);

        err_before = total_errors();
        launch_frame(POOL_AVG, FILL_ONES);
        launch_frame(POOL_MAX, FILL_ZEROS);
        check_restart_gap(frame_cnt - 1);
        end_test("average of all ones and max of zeros", err_before);

        err_before = total_errors();
        launch_frame(POOL_MAX, FILL_RANDOM);
        repeat (4) @(negedge clk);
        if (busy !== 1'b1)
        begin
            $display("busy was not high when the extra start was driven");
            tb_errors++;
        end
        start = 1'b1;  // Frame still running, so this strobe is dropped
        mode  = POOL_AVG;
        @(negedge clk);
        start = 1'b0;
        end_test("start while busy is ignored", err_before);

        err_before = total_errors();
        launch_frame(POOL_MAX, FILL_RANDOM);
        launch_frame(POOL_AVG, FILL_RANDOM);
        check_restart_gap(frame_cnt - 1);
        end_test("back to back frames with mixed modes", err_before);

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_cnt, chk_count, total_errors());
        if (total_errors() == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        while (cycle < TIMEOUT)
            @(posedge clk);
        $display("timeout, the tests did not complete within %0d cycles", TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/pool_data_pkg.sv
verilog/pool_ctrl_pkg.sv
verilog/pool_row_buffer.sv
verilog/pool_alu.sv
verilog/pool_column.sv
verilog/pool_control.sv
verilog/pool_skew_stage.sv
verilog/pool_top.sv
verification/pool_clock_gen.sv
verification/pool_checker.sv
verification/pool_tb.sv

// File: Makefile
# Verilator build and run for the pooling array testbench

VERILATOR ?= verilator
TOP       ?= pool_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
